// File: list.f
+incdir+design
design/intra_pkg.sv
design/intra_cand_gen.sv
design/cand_fifo.sv
design/mode_picker.sv
design/intra_mode_decision.sv
tests/tb_clock.sv
tests/tb_intra_mode_decision.sv

// File: Makefile
# Verilator build and run for the intra mode decision testbench

VERILATOR ?= verilator
TOP       ?= tb_intra_mode_decision
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_intra_mode_decision.sv
// Testbench for the intra mode decision block
// Directed and random 4x4 blocks checked against a behavioural model

`timescale 1ns/1ps

`include "intra_params.svh"

module tb_intra_mode_decision import intra_pkg::*; ();

    localparam int NUM_BLOCKS      = 32;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 200 + 1000;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic [`NPIX*`PIX_W-1:0]    src;
    logic [`BLK*`PIX_W-1:0]     top;
    logic [`BLK*`PIX_W-1:0]     left;
    logic [`PIX_W-1:0]          top_left;
    logic [`LAMBDA_W-1:0]       lambda;
    logic                       busy;
    logic                       done;
    pred_mode_t                 best_mode;
    logic [`SCORE_W-1:0]        best_score;
    logic [`SSE_W-1:0]          best_sse;

    // Expected results in start order
    logic [1:0]                 exp_mode_q  [$];
    logic [`SCORE_W-1:0]        exp_score_q [$];
    logic [`SSE_W-1:0]          exp_sse_q   [$];
    int                         pass_cnt = 0;
    int                         fail_cnt = 0;
    int                         done_cnt = 0;
    logic [31:0]                rng_state = 32'hd6ad_9eac;

    tb_clock #(
        .PERIOD_NS    ( 8.0 ),
        .RESET_CYCLES ( 16  )
    ) u_clock (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    intra_mode_decision DUT (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .start      ( start      ),
        .src        ( src        ),
        .top        ( top        ),
        .left       ( left       ),
        .top_left   ( top_left   ),
        .lambda     ( lambda     ),
        .busy       ( busy       ),
        .done       ( done       ),
        .best_mode  ( best_mode  ),
        .best_score ( best_score ),
        .best_sse   ( best_sse   )
    );

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        if (act_v === exp_v) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("ERR at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
        end
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic model_block(input logic [`NPIX*`PIX_W-1:0] s,
                               input logic [`BLK*`PIX_W-1:0] t,
                               input logic [`BLK*`PIX_W-1:0] l,
                               input logic [`PIX_W-1:0] tl,
                               input logic [`LAMBDA_W-1:0] lam,
                               output logic [1:0] m,
                               output logic [`SCORE_W-1:0] sc,
                               output logic [`SSE_W-1:0] ss);
        int     dc;
        int     p;
        int     d;
        int     cost;
        longint sse_m;
        longint score_m;
        longint best_sc;
        dc = 4;
        best_sc = 0;
        for (int i = 0; i < `BLK; i++) begin
            dc = dc + int'(t[i*`PIX_W +: `PIX_W]) + int'(l[i*`PIX_W +: `PIX_W]);
        end
        dc = dc / 8;
        for (int mode = 0; mode < `NUM_MODES; mode++) begin
            sse_m = 0;
            for (int r = 0; r < `BLK; r++) begin
                for (int c = 0; c < `BLK; c++) begin
                    case (mode)
                        0: p = dc;
                        1: begin
                            p = int'(l[r*`PIX_W +: `PIX_W]) + int'(t[c*`PIX_W +: `PIX_W])
                              - int'(tl);
                            p = (p < 0) ? 0 : ((p > 255) ? 255 : p);
                        end
                        2: p = int'(t[c*`PIX_W +: `PIX_W]);
                        default: p = int'(l[r*`PIX_W +: `PIX_W]);
                    endcase
                    d = int'(s[(r*`BLK+c)*`PIX_W +: `PIX_W]) - p;
                    sse_m = sse_m + d * d;
                end
            end
            case (mode)
                0: cost = int'(`COST_DC);
                1: cost = int'(`COST_TM);
                2: cost = int'(`COST_VE);
                default: cost = int'(`COST_HE);
            endcase
            score_m = (sse_m << 8) + longint'(lam) * cost;
            // Later mode wins a tie
            if (mode == 0 || score_m <= best_sc) begin
                best_sc = score_m;
                m  = 2'(mode);
                sc = score_m[`SCORE_W-1:0];
                ss = sse_m[`SSE_W-1:0];
            end
        end
    endtask

    task automatic start_block(input logic [`NPIX*`PIX_W-1:0] s,
                               input logic [`BLK*`PIX_W-1:0] t,
                               input logic [`BLK*`PIX_W-1:0] l,
                               input logic [`PIX_W-1:0] tl,
                               input logic [`LAMBDA_W-1:0] lam);
        logic [1:0]          m;
        logic [`SCORE_W-1:0] sc;
        logic [`SSE_W-1:0]   ss;
        model_block(s, t, l, tl, lam, m, sc, ss);
        exp_mode_q.push_back(m);
        exp_score_q.push_back(sc);
        exp_sse_q.push_back(ss);
        @(posedge clk);
        while (busy)
            @(posedge clk);
        start    <= 1'b1;
        src      <= s;
        top      <= t;
        left     <= l;
        top_left <= tl;
        lambda   <= lam;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_results();
        @(negedge clk);
        while (exp_mode_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic check_result();
        logic [1:0]          m;
        logic [`SCORE_W-1:0] sc;
        logic [`SSE_W-1:0]   ss;
        m  = exp_mode_q.pop_front();
        sc = exp_score_q.pop_front();
        ss = exp_sse_q.pop_front();
        check_val("best_mode", m, best_mode);
        check_val("best_score", sc, best_score);
        check_val("best_sse", ss, best_sse);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-22s finished, %0d errors", name, fail_cnt - errs_before);
    endtask

    // Done pulse seen one edge late, with the results it published
    always @(posedge clk) begin
        if (rst_n && done) begin
            done_cnt++;
            if (exp_mode_q.size() == 0) begin
                fail_cnt++;
                $display("unexpected done pulse at %0t with no block pending", $time);
            end else begin
                check_result();
            end
        end
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic check_reset_state();
        int errs;
        errs = fail_cnt;
        @(negedge clk);
        check_val("done", 0, done);
        check_val("busy", 0, busy);
        check_val("best_mode", MODE_DC, best_mode);
        check_val("best_score", 0, best_score);
        check_val("best_sse", 0, best_sse);
        report_test("reset state", errs);
    endtask

    task automatic run_directed_blocks();
        logic [`NPIX*`PIX_W-1:0] s;
        logic [`BLK*`PIX_W-1:0]  t;
        logic [`BLK*`PIX_W-1:0]  l;
        int                      errs;
        errs = fail_cnt;
        t = {8'hc0, 8'h80, 8'h40, 8'h10};
        l = {8'he0, 8'h90, 8'h30, 8'h20};
        // Every row repeats the top edge
        for (int r = 0; r < `BLK; r++) begin
            for (int c = 0; c < `BLK; c++) begin
                s[(r*`BLK+c)*`PIX_W +: `PIX_W] = t[c*`PIX_W +: `PIX_W];
            end
        end
        start_block(s, t, l, 8'h50, 16'd1);
        wait_results();
        check_val("best_mode", MODE_VE, best_mode);
        check_val("best_sse", 0, best_sse);
        // Every column repeats the left edge
        for (int r = 0; r < `BLK; r++) begin
            for (int c = 0; c < `BLK; c++) begin
                s[(r*`BLK+c)*`PIX_W +: `PIX_W] = l[r*`PIX_W +: `PIX_W];
            end
        end
        start_block(s, t, l, 8'h50, 16'd1);
        wait_results();
        check_val("best_mode", MODE_HE, best_mode);
        check_val("best_sse", 0, best_sse);
        // Flat block, all SSEs zero so header cost decides
        start_block({`NPIX{8'h80}}, {`BLK{8'h80}}, {`BLK{8'h80}}, 8'h80, 16'hffff);
        wait_results();
        check_val("best_mode", MODE_DC, best_mode);
        check_val("best_sse", 0, best_sse);
        // Plane gradient
        t = {8'd40, 8'd30, 8'd20, 8'd10};
        l = {8'd80, 8'd70, 8'd60, 8'd50};
        for (int r = 0; r < `BLK; r++) begin
            for (int c = 0; c < `BLK; c++) begin
                s[(r*`BLK+c)*`PIX_W +: `PIX_W] =
                    l[r*`PIX_W +: `PIX_W] + t[c*`PIX_W +: `PIX_W] - 8'd5;
            end
        end
        start_block(s, t, l, 8'd5, 16'd1);
        wait_results();
        check_val("best_mode", MODE_TM, best_mode);
        check_val("best_sse", 0, best_sse);
        report_test("directed blocks", errs);
    endtask

    task automatic run_random_blocks();
        logic [`NPIX*`PIX_W-1:0] s;
        logic [31:0]             t;
        logic [31:0]             l;
        logic [31:0]             r;
        int                      errs;
        errs = fail_cnt;
        for (int b = 0; b < 20; b++) begin
            for (int w = 0; w < 4; w++) begin
                s[w*32 +: 32] = next_rand();
            end
            t = next_rand();
            l = next_rand();
            r = next_rand();
            start_block(s, t, l, r[7:0], r[31:16] >> r[11:8]);
            wait_results();
        end
        report_test("random blocks", errs);
    endtask

    task automatic run_back_to_back();
        logic [`NPIX*`PIX_W-1:0] s;
        logic [31:0]             t;
        logic [31:0]             l;
        int                      errs;
        int                      d0;
        errs = fail_cnt;
        d0 = done_cnt;
        for (int b = 0; b < 6; b++) begin
            for (int w = 0; w < 4; w++) begin
                s[w*32 +: 32] = next_rand();
            end
            t = next_rand();
            l = next_rand();
            start_block(s, t, l, t[15:8] ^ l[7:0], 16'(b * 1500 + 3));
        end
        wait_results();
        check_val("done pulses", 6, done_cnt - d0);
        report_test("back-to-back blocks", errs);
    endtask

    task automatic run_start_while_busy();
        logic [`NPIX*`PIX_W-1:0] s;
        int                      errs;
        int                      d0;
        errs = fail_cnt;
        d0 = done_cnt;
        for (int w = 0; w < 4; w++) begin
            s[w*32 +: 32] = next_rand();
        end
        start_block(s, 32'h1020_3040, 32'h5060_7080, 8'h44, 16'd200);
        @(posedge clk);
        check_val("busy", 1, busy);
        // Second block must be dropped
        start    <= 1'b1;
        src      <= ~s;
        top      <= 32'hf0e0_d0c0;
        left     <= 32'h0102_0304;
        top_left <= 8'h99;
        lambda   <= 16'd7;
        @(posedge clk);
        start <= 1'b0;
        wait_results();
        repeat (40) @(negedge clk);
        check_val("done pulses", 1, done_cnt - d0);
        report_test("start while busy", errs);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        start    <= 1'b0;
        src      <= '0;
        top      <= '0;
        left     <= '0;
        top_left <= '0;
        lambda   <= '0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        check_reset_state();
        run_directed_blocks();
        run_random_blocks();
        run_back_to_back();
        run_start_while_busy();
        $display("summary: %0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not complete within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
// Testbench clock and reset
// Free-running clock and an active-low reset held for a set number of cycles

`timescale 1ns/1ps

module tb_clock #(
     parameter real PERIOD_NS    = 8.0
    ,parameter int  RESET_CYCLES = 16
)(
     output logic clk
    ,output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: design/intra_mode_decision.sv
// Intra mode decision top level
// Candidate generator feeding the mode picker through a candidate FIFO

`timescale 1ns/1ps

`include "intra_params.svh"

module intra_mode_decision import intra_pkg::*; (
     input  logic                        clk
    ,input  logic                        rst_n
    ,input  logic                        start
    ,input  logic [`NPIX*`PIX_W-1:0]     src
    ,input  logic [`BLK*`PIX_W-1:0]      top
    ,input  logic [`BLK*`PIX_W-1:0]      left
    ,input  logic [`PIX_W-1:0]           top_left
    ,input  logic [`LAMBDA_W-1:0]        lambda
    ,output logic                        busy
    ,output logic                        done
    ,output pred_mode_t                  best_mode
    ,output logic [`SCORE_W-1:0]         best_score
    ,output logic [`SSE_W-1:0]           best_sse
);

    localparam int CAND_W = $bits(pred_mode_t) + `SSE_W + `LAMBDA_W;

    logic                    cand_valid;
    logic                    cand_ready;
    pred_mode_t              cand_mode;
    logic [`SSE_W-1:0]       cand_sse;
    logic [`LAMBDA_W-1:0]    cand_lambda;
    logic                    out_valid;
    logic                    out_ready;
    logic [CAND_W-1:0]       out_data;
    pred_mode_t              out_mode;
    logic [`SSE_W-1:0]       out_sse;
    logic [`LAMBDA_W-1:0]    out_lambda;

    // FIFO word is {mode, sse, lambda}
    assign out_mode   = pred_mode_t'(out_data[CAND_W-1 -: $bits(pred_mode_t)]);
    assign out_sse    = out_data[`SSE_W+`LAMBDA_W-1:`LAMBDA_W];
    assign out_lambda = out_data[`LAMBDA_W-1:0];

    intra_cand_gen u_cand_gen (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .start       ( start       ),
        .src         ( src         ),
        .top         ( top         ),
        .left        ( left        ),
        .top_left    ( top_left    ),
        .lambda      ( lambda      ),
        .busy        ( busy        ),
        .cand_valid  ( cand_valid  ),
        .cand_ready  ( cand_ready  ),
        .cand_mode   ( cand_mode   ),
        .cand_sse    ( cand_sse    ),
        .cand_lambda ( cand_lambda )
    );

    cand_fifo #(
        .WIDTH ( CAND_W           ),
        .DEPTH ( `CAND_FIFO_DEPTH )
    ) u_cand_fifo (
        .clk       ( clk                                  ),
        .rst_n     ( rst_n                                ),
        .in_valid  ( cand_valid                           ),
        .in_ready  ( cand_ready                           ),
        .in_data   ( {cand_mode, cand_sse, cand_lambda}   ),
        .out_valid ( out_valid                            ),
        .out_ready ( out_ready                            ),
        .out_data  ( out_data                             )
    );

    mode_picker u_mode_picker (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .in_valid   ( out_valid  ),
        .in_ready   ( out_ready  ),
        .in_mode    ( out_mode   ),
        .in_sse     ( out_sse    ),
        .in_lambda  ( out_lambda ),
        .done       ( done       ),
        .best_mode  ( best_mode  ),
        .best_score ( best_score ),
        .best_sse   ( best_sse   )
    );

endmodule

// File: design/mode_picker.sv
// Intra mode picker
// Scores each candidate as (SSE << 8) + lambda * header cost and keeps
// the lowest score per block, later modes winning ties

`timescale 1ns/1ps

`include "intra_params.svh"

module mode_picker import intra_pkg::*; (
     input  logic                        clk
    ,input  logic                        rst_n
    ,input  logic                        in_valid
    ,output logic                        in_ready
    ,input  pred_mode_t                  in_mode
    ,input  logic [`SSE_W-1:0]           in_sse
    ,input  logic [`LAMBDA_W-1:0]        in_lambda
    ,output logic                        done
    ,output pred_mode_t                  best_mode
    ,output logic [`SCORE_W-1:0]         best_score
    ,output logic [`SSE_W-1:0]           best_sse
);

    picker_state_t                   state;
    logic [$clog2(`NUM_MODES)-1:0]   cnt;
    pred_mode_t                      mode_q;
    logic [`SSE_W-1:0]               sse_q;
    logic [`LAMBDA_W-1:0]            lambda_q;
    logic [`LAMBDA_W-1:0]            hdr_cost;
    logic [2*`LAMBDA_W-1:0]          rate_prod;
    logic [`SCORE_W-1:0]             dist_term;
    logic [`SCORE_W-1:0]             score_q;
    pred_mode_t                      run_mode;
    logic [`SCORE_W-1:0]             run_score;
    logic [`SSE_W-1:0]               run_sse;
    logic                            take;
    logic                            last;

    assign in_ready = (state == P_IDLE);

    always_comb begin
        case (mode_q)
            MODE_DC: hdr_cost = `COST_DC;
            MODE_TM: hdr_cost = `COST_TM;
            MODE_VE: hdr_cost = `COST_VE;
            default: hdr_cost = `COST_HE;
        endcase
    end

    assign rate_prod = lambda_q * hdr_cost;
    assign dist_term = {{(`SCORE_W-`SSE_W){1'b0}}, sse_q} << 8;

    // First candidate of a block always seeds the running best
    assign take = (cnt == '0) || (score_q <= run_score);
    assign last = (cnt == `NUM_MODES - 1);

    // ------------------------------------------------------------------------
    // FSM and block results
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= P_IDLE;
            cnt        <= '0;
            done       <= 1'b0;
            best_mode  <= MODE_DC;
            best_score <= '0;
            best_sse   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                P_IDLE:  if (in_valid) state <= P_SCORE;
                P_SCORE: state <= P_COMP;
                P_COMP: begin
                    state <= P_IDLE;
                    if (last) begin
                        cnt        <= '0;
                        done       <= 1'b1;
                        best_mode  <= take ? mode_q  : run_mode;
                        best_score <= take ? score_q : run_score;
                        best_sse   <= take ? sse_q   : run_sse;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // Candidate, score and running best
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            mode_q   <= in_mode;
            sse_q    <= in_sse;
            lambda_q <= in_lambda;
        end
        if (state == P_SCORE)
            score_q <= dist_term + {{(`SCORE_W-2*`LAMBDA_W){1'b0}}, rate_prod};
        if (state == P_COMP && take) begin
            run_mode  <= mode_q;
            run_score <= score_q;
            run_sse   <= sse_q;
        end
    end

    // Candidates arrive in emission order, so the counter tracks the mode
    a_cnt_mode: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |-> in_mode == pred_mode_t'(cnt)
    );

endmodule

// File: design/cand_fifo.sv
// Candidate buffer
// Circular FIFO with valid/ready on both sides, push and pop may coincide

`timescale 1ns/1ps

`include "intra_params.svh"

module cand_fifo #(
     parameter int WIDTH = 8
    ,parameter int DEPTH = `CAND_FIFO_DEPTH
)(
     input  logic                clk
    ,input  logic                rst_n
    ,input  logic                in_valid
    ,output logic                in_ready
    ,input  logic [WIDTH-1:0]    in_data
    ,output logic                out_valid
    ,input  logic                out_ready
    ,output logic [WIDTH-1:0]    out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;
    logic                full;
    logic                push;
    logic                pop;

    assign full      = (count == DEPTH);
    assign in_ready  = !full;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    // Pointers wrap on their own at power-of-two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) full |=> $stable(wr_ptr)
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid |=> $stable(rd_ptr)
    );

endmodule

// File: design/intra_cand_gen.sv
// Intra candidate generator
// Latches a 4x4 block with its neighbours, then forms the DC, TM, VE
// and HE predictions in turn and emits one SSE candidate per cycle

`timescale 1ns/1ps

`include "intra_params.svh"

module intra_cand_gen import intra_pkg::*; (
     input  logic                        clk
    ,input  logic                        rst_n
    ,input  logic                        start
    ,input  logic [`NPIX*`PIX_W-1:0]     src
    ,input  logic [`BLK*`PIX_W-1:0]      top
    ,input  logic [`BLK*`PIX_W-1:0]      left
    ,input  logic [`PIX_W-1:0]           top_left
    ,input  logic [`LAMBDA_W-1:0]        lambda
    ,output logic                        busy
    ,output logic                        cand_valid
    ,input  logic                        cand_ready
    ,output pred_mode_t                  cand_mode
    ,output logic [`SSE_W-1:0]           cand_sse
    ,output logic [`LAMBDA_W-1:0]        cand_lambda
);

    logic                        accept;
    logic                        fire;
    logic [`NPIX*`PIX_W-1:0]     src_q;
    logic [`BLK*`PIX_W-1:0]      top_q;
    logic [`BLK*`PIX_W-1:0]      left_q;
    logic [`PIX_W-1:0]           top_left_q;
    logic [`LAMBDA_W-1:0]        lambda_q;
    pred_mode_t                  mode_q;
    logic [`PIX_W+2:0]           edge_sum;
    logic [`PIX_W+2:0]           dc_round;
    logic [`PIX_W-1:0]           dc_val;
    logic signed [`PIX_W+1:0]    tm_raw;
    logic [`PIX_W-1:0]           pred_pix;
    logic [`PIX_W-1:0]           src_pix;
    logic [`PIX_W-1:0]           abs_diff;
    logic [2*`PIX_W-1:0]         sq;
    logic [`SSE_W-1:0]           sse_acc;

    assign accept      = start && !busy;
    assign fire        = cand_valid && cand_ready;
    assign cand_valid  = busy;
    assign cand_mode   = mode_q;
    assign cand_sse    = sse_acc;
    assign cand_lambda = lambda_q;

    // ------------------------------------------------------------------------
    // Control: busy spans from sampling to the HE transfer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            mode_q <= MODE_DC;
        end else if (accept) begin
            busy   <= 1'b1;
            mode_q <= MODE_DC;
        end else if (fire) begin
            if (mode_q == MODE_HE)
                busy <= 1'b0;
            mode_q <= pred_mode_t'(mode_q + 2'd1);
        end
    end

    // Block and neighbours
    always_ff @(posedge clk) begin
        if (accept) begin
            src_q      <= src;
            top_q      <= top;
            left_q     <= left;
            top_left_q <= top_left;
            lambda_q   <= lambda;
        end
    end

    // ------------------------------------------------------------------------
    // Prediction and SSE for the current mode
    // ------------------------------------------------------------------------
    always_comb begin
        edge_sum = '0;
        for (int i = 0; i < `BLK; i++) begin
            edge_sum = edge_sum + top_q[i*`PIX_W +: `PIX_W] + left_q[i*`PIX_W +: `PIX_W];
        end
    end

    // Rounded mean of the eight edge pixels
    assign dc_round = edge_sum + {{`PIX_W{1'b0}}, 3'b100};
    assign dc_val   = dc_round[`PIX_W+2:3];

    always_comb begin
        sse_acc  = '0;
        tm_raw   = '0;
        pred_pix = '0;
        src_pix  = '0;
        abs_diff = '0;
        sq       = '0;
        for (int r = 0; r < `BLK; r++) begin
            for (int c = 0; c < `BLK; c++) begin
                tm_raw = $signed({2'b00, left_q[r*`PIX_W +: `PIX_W]})
                       + $signed({2'b00, top_q[c*`PIX_W +: `PIX_W]})
                       - $signed({2'b00, top_left_q});
                case (mode_q)
                    MODE_DC: pred_pix = dc_val;
                    MODE_TM: begin
                        // Clip to pixel range
                        if (tm_raw < 0)
                            pred_pix = '0;
                        else if (tm_raw > 255)
                            pred_pix = '1;
                        else
                            pred_pix = tm_raw[`PIX_W-1:0];
                    end
                    MODE_VE: pred_pix = top_q[c*`PIX_W +: `PIX_W];
                    default: pred_pix = left_q[r*`PIX_W +: `PIX_W];
                endcase
                src_pix  = src_q[(r*`BLK+c)*`PIX_W +: `PIX_W];
                abs_diff = (src_pix > pred_pix) ? src_pix - pred_pix : pred_pix - src_pix;
                sq       = abs_diff * abs_diff;
                sse_acc  = sse_acc + {{(`SSE_W-2*`PIX_W){1'b0}}, sq};
            end
        end
    end

    // A stalled candidate keeps its mode until it is taken
    a_mode_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        cand_valid && !cand_ready |=> cand_valid && $stable(cand_mode)
    );

endmodule

// File: design/intra_pkg.sv
// Intra mode decision types
// Prediction mode encoding and the picker FSM states

package intra_pkg;

    // Order matches the candidate emission order
    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } pred_mode_t;

    typedef enum logic [1:0] {
        P_IDLE  = 2'd0,
        P_SCORE = 2'd1,
        P_COMP  = 2'd2
    } picker_state_t;

endpackage

// File: design/intra_params.svh
// Intra mode decision parameters
// Block geometry, datapath widths and fixed per-mode header costs

`ifndef INTRA_PARAMS_SVH
`define INTRA_PARAMS_SVH

// Block geometry
`define BLK             4
`define NPIX            16
`define PIX_W           8

// Datapath widths
`define SSE_W           32
`define LAMBDA_W        16
`define SCORE_W         48

// Mode set and candidate buffering
`define NUM_MODES       4
`define CAND_FIFO_DEPTH 4

// Header cost per mode, scaled by lambda
`define COST_DC         16'd663
`define COST_TM         16'd919
`define COST_VE         16'd872
`define COST_HE         16'd919

`endif
